/* build.f */
+incdir+logic
logic/loader_pkg.sv
logic/delay_line.sv
logic/cfg_sequencer.sv
logic/load_arbiter.sv
logic/addr_router.sv
logic/mem_model.sv
logic/host_mmio.sv
logic/boot_loader_top.sv
tb/loader_props.sv
tb/loader_tb.sv

/* tb/loader_tb.sv */
// ----------------------------
// Boot loader testbench
// Runs nbf loads after config
// and checks every response
// against a reference model
// ----------------------------

`include "loader_macros.svh"

module loader_tb;

   import loader_pkg::*;

   localparam int burst_n_lp = 40;
   // Arbiter, router, then the device
   localparam int lat_lp     = 2 + `LD_DEV_LATENCY;
   localparam int load_n_lp  = `LD_CFG_ELS + 2 + burst_n_lp + 2 + 1;
   localparam int limit_lp   = 5 + 4 * (2 + `LD_CFG_ELS) + load_n_lp * (lat_lp + 4) + 200;
   localparam logic [`LD_ADDR_W-1:0] host_lp = `LD_HOST_BASE;

   logic                  clk_i = 1'b0;
   logic                  rst_i;
   logic                  nbf_v_i;
   ld_op_e                nbf_op_i;
   logic [`LD_ADDR_W-1:0] nbf_addr_i;
   logic [`LD_DATA_W-1:0] nbf_data_i;
   logic                  nbf_ready_o;
   logic                  resp_v_o;
   logic [`LD_DATA_W-1:0] resp_data_o;
   logic                  freeze_o;
   logic                  char_v_o;
   logic [7:0]            char_o;
   logic                  program_finish_o;
   logic                  cfg_done_o;

   // Reference model state
   logic [`LD_DATA_W-1:0] ref_mem [int];
   logic                  ref_freeze;
   int                    finish_due = -1;

   // Expected events, tagged with the cycle they are due
   int                    resp_due_q [$];
   logic [`LD_DATA_W-1:0] resp_exp_q [$];
   int                    char_due_q [$];
   logic [7:0]            char_exp_q [$];
   logic [`LD_DATA_W-1:0] exp_data;

   int          cyc = 0;
   int          errors = 0;
   int          checks = 0;
   int          err_mark = 0;
   logic [31:0] rand_state = 32'hda41_02e4;

   boot_loader_top uut
   (
      .clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.nbf_v_i(nbf_v_i)
      ,.nbf_op_i(nbf_op_i)
      ,.nbf_addr_i(nbf_addr_i)
      ,.nbf_data_i(nbf_data_i)
      ,.nbf_ready_o(nbf_ready_o)
      ,.resp_v_o(resp_v_o)
      ,.resp_data_o(resp_data_o)
      ,.freeze_o(freeze_o)
      ,.char_v_o(char_v_o)
      ,.char_o(char_o)
      ,.program_finish_o(program_finish_o)
      ,.cfg_done_o(cfg_done_o)
   );

   always #50 clk_i = ~clk_i;

   always @(posedge clk_i)
      cyc <= cyc + 1;

   function automatic logic [31:0] next_rand();
      logic [31:0] s;
      s = rand_state;
      s ^= s << 13;
      s ^= s >> 17;
      s ^= s << 5;
      rand_state = s;
      return s;
   endfunction

   // Applies one load to the model and gives the expected response data
   function automatic logic [`LD_DATA_W-1:0] ref_load(input ld_op_e op,
      input logic [`LD_ADDR_W-1:0] addr, input logic [`LD_DATA_W-1:0] data);
      int                    idx;
      logic [`LD_DATA_W-1:0] rdata;
      rdata = '0;
      if (addr < host_lp)
      begin
         idx = addr % `LD_MEM_WORDS;
         if (op == LD_OP_WRITE)
            ref_mem[idx] = data;
         else if (ref_mem.exists(idx))
            rdata = ref_mem[idx];
         else
            rdata = 'x;
      end
      else if (addr == host_lp + `LD_FREEZE_OFS)
      begin
         if (op == LD_OP_WRITE)
            ref_freeze = data[0];
         else
            rdata = `LD_DATA_W'(ref_freeze);
      end
      return rdata;
   endfunction

   // Outputs are sampled mid-cycle, where they are stable
   always @(negedge clk_i)
   begin
      if (!rst_i)
      begin
         assert (resp_v_o || resp_due_q.size() == 0 || resp_due_q[0] > cyc)
         else
         begin
            $display("[ERROR] t=%0t no response for the load due at cycle %0d",
                     $time, resp_due_q[0]);
            errors++;
            void'(resp_due_q.pop_front());
            void'(resp_exp_q.pop_front());
         end
         if (resp_v_o)
         begin
            checks++;
            assert (resp_due_q.size() != 0)
            else
            begin
               $display("[ERROR] t=%0t resp_v_o high with no load outstanding", $time);
               errors++;
            end
            if (resp_due_q.size() != 0)
            begin
               assert (resp_due_q[0] == cyc)
               else
               begin
                  $display("[ERROR] t=%0t response came at cycle %0d but was due at cycle %0d",
                           $time, cyc, resp_due_q[0]);
                  errors++;
               end
               assert (resp_data_o === resp_exp_q[0])
               else
               begin
                  $display("[FAIL] t=%0t resp_data_o expected %h got %h",
                           $time, resp_exp_q[0], resp_data_o);
                  errors++;
               end
               void'(resp_due_q.pop_front());
               void'(resp_exp_q.pop_front());
            end
         end

         assert (char_v_o || char_due_q.size() == 0 || char_due_q[0] > cyc)
         else
         begin
            $display("[ERROR] t=%0t no char_v_o pulse for the putchar due at cycle %0d",
                     $time, char_due_q[0]);
            errors++;
            void'(char_due_q.pop_front());
            void'(char_exp_q.pop_front());
         end
         if (char_v_o)
         begin
            checks++;
            assert (char_due_q.size() != 0 && char_due_q[0] == cyc)
            else
            begin
               $display("[ERROR] t=%0t char_v_o pulse at cycle %0d was not expected", $time, cyc);
               errors++;
            end
            if (char_due_q.size() != 0)
            begin
               assert (char_o === char_exp_q[0])
               else
               begin
                  $display("[FAIL] t=%0t char_o expected %h got %h", $time, char_exp_q[0], char_o);
                  errors++;
               end
               void'(char_due_q.pop_front());
               void'(char_exp_q.pop_front());
            end
         end

         if (finish_due >= 0 && cyc >= finish_due)
         begin
            checks++;
            assert (program_finish_o === 1'b1)
            else
            begin
               $display("[FAIL] t=%0t program_finish_o expected 1 got %b", $time, program_finish_o);
               errors++;
            end
         end
         else
         begin
            assert (program_finish_o === 1'b0)
            else
            begin
               $display("[FAIL] t=%0t program_finish_o expected 0 got %b", $time, program_finish_o);
               errors++;
            end
         end

         // Accepted on the coming rising edge
         if (nbf_v_i && nbf_ready_o)
         begin
            exp_data = ref_load(nbf_op_i, nbf_addr_i, nbf_data_i);
            resp_due_q.push_back(cyc + lat_lp);
            resp_exp_q.push_back(exp_data);
            if (nbf_op_i == LD_OP_WRITE && nbf_addr_i == host_lp + `LD_PUTCHAR_OFS)
            begin
               char_due_q.push_back(cyc + lat_lp);
               char_exp_q.push_back(nbf_data_i[7:0]);
            end
            if (nbf_op_i == LD_OP_WRITE && nbf_addr_i == host_lp + `LD_FINISH_OFS
                && finish_due < 0)
               finish_due = cyc + lat_lp;
         end
      end
   end

   task automatic issue_load(input ld_op_e op, input logic [`LD_ADDR_W-1:0] addr,
                             input logic [`LD_DATA_W-1:0] data);
      @(posedge clk_i);
      nbf_v_i    <= 1'b1;
      nbf_op_i   <= op;
      nbf_addr_i <= addr;
      nbf_data_i <= data;
   endtask

   task automatic go_idle();
      @(posedge clk_i);
      nbf_v_i <= 1'b0;
   endtask

   task automatic drain();
      int n;
      n = 0;
      while ((resp_due_q.size() != 0 || char_due_q.size() != 0) && n < 4 * lat_lp)
      begin
         @(negedge clk_i);
         n++;
      end
   endtask

   task automatic end_test(input int num, input string name);
      $display("Test %0d %s: %0d errors", num, name, errors - err_mark);
      err_mark = errors;
   endtask

   initial
   begin
      repeat (limit_lp) @(posedge clk_i);
      $display("[ERROR] Watchdog expired after %0d cycles, run stopped", limit_lp);
      $display("Result: FAILED");
      $finish;
   end

   initial
   begin
      int                    n;
      logic [31:0]           r;
      logic [`LD_ADDR_W-1:0] addr;
      logic [`LD_DATA_W-1:0] data;
      logic [`LD_ADDR_W-1:0] wr_q [$];

      rst_i      = 1'b1;
      nbf_v_i    = 1'b0;
      nbf_op_i   = LD_OP_READ;
      nbf_addr_i = '0;
      nbf_data_i = '0;
      // State once configuration has finished
      ref_freeze = 1'b0;
      for (int i = 0; i < `LD_CFG_ELS; i++)
         ref_mem[i] = '0;
      repeat (5) @(posedge clk_i);
      rst_i <= 1'b0;

      // Test 1: freeze pulse, done, cleared words
      n = 0;
      while (freeze_o !== 1'b1 && n < 40)
      begin
         @(negedge clk_i);
         n++;
      end
      assert (freeze_o === 1'b1)
      else
      begin
         $display("[ERROR] t=%0t freeze_o did not rise after reset", $time);
         errors++;
      end
      n = 0;
      while (freeze_o !== 1'b0 && n < 40)
      begin
         @(negedge clk_i);
         n++;
      end
      assert (freeze_o === 1'b0)
      else
      begin
         $display("[ERROR] t=%0t freeze_o did not fall", $time);
         errors++;
      end
      n = 0;
      while (cfg_done_o !== 1'b1 && n < 40)
      begin
         @(negedge clk_i);
         n++;
      end
      assert (cfg_done_o === 1'b1 && nbf_ready_o === 1'b1)
      else
      begin
         $display("[ERROR] t=%0t cfg_done_o or nbf_ready_o never rose", $time);
         errors++;
      end
      for (int i = 0; i < `LD_CFG_ELS; i++)
         issue_load(LD_OP_READ, `LD_ADDR_W'(i), '0);
      go_idle();
      drain();
      end_test(1, "config and clear");

      // Test 2: single write then read
      issue_load(LD_OP_WRITE, 32'h0000_1234, 64'hdead_beef_0123_4567);
      issue_load(LD_OP_READ, 32'h0000_1234, '0);
      go_idle();
      drain();
      end_test(2, "write then read");

      // Test 3: random back-to-back burst
      for (int i = 0; i < burst_n_lp; i++)
      begin
         r = next_rand();
         if (wr_q.size() == 0 || r[0])
         begin
            addr = next_rand() & 32'h000f_ffff;
            data[63:32] = next_rand();
            data[31:0] = next_rand();
            wr_q.push_back(addr);
            issue_load(LD_OP_WRITE, addr, data);
         end
         else
         begin
            addr = wr_q[r[15:8] % wr_q.size()];
            // Other upper bits, same memory word
            addr[19:8] = r[31:20];
            issue_load(LD_OP_READ, addr, '0);
         end
      end
      go_idle();
      drain();
      end_test(3, "random burst");

      // Test 4: putchar, then read back freeze
      issue_load(LD_OP_WRITE, host_lp + `LD_PUTCHAR_OFS, 64'h0000_0000_0000_0a41);
      issue_load(LD_OP_READ, host_lp + `LD_FREEZE_OFS, '0);
      go_idle();
      drain();
      end_test(4, "putchar and freeze read");

      // Test 5: finish stays set
      issue_load(LD_OP_WRITE, host_lp + `LD_FINISH_OFS, 64'h1);
      go_idle();
      drain();
      repeat (10) @(negedge clk_i);
      end_test(5, "finish");

      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

/* tb/loader_props.sv */
// ----------------------------
// Boot loader properties
// Response, putchar and finish
// rules at the top level
// ----------------------------

module loader_props
(
   input logic clk_i,
   input logic rst_i,
   input logic cfg_done_i,
   input logic resp_v_i,
   input logic char_v_i,
   input logic finish_i
);

   // No load response before configuration is complete
   resp_after_done: assert property (@(posedge clk_i) disable iff (rst_i)
      !cfg_done_i |-> !resp_v_i)
      else $error("resp_v_o high while cfg_done_o is low");

   // One putchar write gives a one-cycle strobe
   char_single: assert property (@(posedge clk_i) disable iff (rst_i)
      char_v_i |=> !char_v_i)
      else $error("char_v_o held for more than one cycle");

   // Finish is sticky until reset
   finish_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
      finish_i |=> finish_i)
      else $error("program_finish_o fell outside reset");

endmodule

bind boot_loader_top loader_props props
(
   .clk_i(clk_i)
   ,.rst_i(rst_i)
   ,.cfg_done_i(cfg_done_o)
   ,.resp_v_i(resp_v_o)
   ,.char_v_i(char_v_o)
   ,.finish_i(program_finish_o)
);

/* logic/boot_loader_top.sv */
// ----------------------------
// Boot loader top
// Config sequencer, arbiter,
// router, memory and host MMIO
// ----------------------------

`include "loader_macros.svh"

module boot_loader_top
(
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  nbf_v_i,
   input  loader_pkg::ld_op_e    nbf_op_i,
   input  logic [`LD_ADDR_W-1:0] nbf_addr_i,
   input  logic [`LD_DATA_W-1:0] nbf_data_i,
   output logic                  nbf_ready_o,
   output logic                  resp_v_o,
   output logic [`LD_DATA_W-1:0] resp_data_o,
   output logic                  freeze_o,
   output logic                  char_v_o,
   output logic [7:0]            char_o,
   output logic                  program_finish_o,
   output logic                  cfg_done_o
);

   import loader_pkg::*;

   logic     cfg_cmd_v;
   ld_cmd_s  cfg_cmd;
   logic     cfg_resp_v;
   logic     arb_cmd_v;
   ld_cmd_s  arb_cmd;
   logic     mem_cmd_v;
   logic     host_cmd_v;
   ld_cmd_s  dev_cmd;
   logic     mem_resp_v;
   ld_resp_s mem_resp;
   logic     host_resp_v;
   ld_resp_s host_resp;

   cfg_sequencer
   #(
      .skip_init_p(0)
   )
   cfg_loader
   (
      .clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.cfg_cmd_v_o(cfg_cmd_v)
      ,.cfg_cmd_o(cfg_cmd)
      ,.cfg_resp_v_i(cfg_resp_v)
      ,.cfg_done_o(cfg_done_o)
   );

   load_arbiter arbiter
   (
      .clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.cfg_cmd_v_i(cfg_cmd_v)
      ,.cfg_cmd_i(cfg_cmd)
      ,.cfg_done_i(cfg_done_o)
      ,.nbf_v_i(nbf_v_i)
      ,.nbf_op_i(nbf_op_i)
      ,.nbf_addr_i(nbf_addr_i)
      ,.nbf_data_i(nbf_data_i)
      ,.nbf_ready_o(nbf_ready_o)
      ,.cmd_v_o(arb_cmd_v)
      ,.cmd_o(arb_cmd)
   );

   addr_router router
   (
      .clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.cmd_v_i(arb_cmd_v)
      ,.cmd_i(arb_cmd)
      ,.mem_cmd_v_o(mem_cmd_v)
      ,.host_cmd_v_o(host_cmd_v)
      ,.dev_cmd_o(dev_cmd)
      ,.mem_resp_v_i(mem_resp_v)
      ,.mem_resp_i(mem_resp)
      ,.host_resp_v_i(host_resp_v)
      ,.host_resp_i(host_resp)
      ,.cfg_resp_v_o(cfg_resp_v)
      ,.resp_v_o(resp_v_o)
      ,.resp_data_o(resp_data_o)
   );

   mem_model mem
   (
      .clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.cmd_v_i(mem_cmd_v)
      ,.cmd_i(dev_cmd)
      ,.resp_v_o(mem_resp_v)
      ,.resp_o(mem_resp)
   );

   host_mmio host
   (
      .clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.cmd_v_i(host_cmd_v)
      ,.cmd_i(dev_cmd)
      ,.resp_v_o(host_resp_v)
      ,.resp_o(host_resp)
      ,.freeze_o(freeze_o)
      ,.char_v_o(char_v_o)
      ,.char_o(char_o)
      ,.program_finish_o(program_finish_o)
   );

endmodule

/* logic/host_mmio.sv */
// ----------------------------
// Host MMIO block
// Freeze, putchar and finish
// registers behind one window
// ----------------------------

`include "loader_macros.svh"

module host_mmio
(
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 cmd_v_i,
   input  loader_pkg::ld_cmd_s  cmd_i,
   output logic                 resp_v_o,
   output loader_pkg::ld_resp_s resp_o,
   output logic                 freeze_o,
   output logic                 char_v_o,
   output logic [7:0]           char_o,
   output logic                 program_finish_o
);

   import loader_pkg::*;

   logic [`LD_ADDR_W-1:0]     offset;
   logic                      is_freeze;
   logic                      is_putchar;
   logic                      is_finish;
   logic                      wr;
   logic                      freeze_r;
   logic [`LD_DEV_LATENCY-1:0] finish_sr;
   ld_resp_s                  resp;

   assign offset     = cmd_i.addr - `LD_ADDR_W'(`LD_HOST_BASE);
   assign is_freeze  = (offset == `LD_ADDR_W'(`LD_FREEZE_OFS));
   assign is_putchar = (offset == `LD_ADDR_W'(`LD_PUTCHAR_OFS));
   assign is_finish  = (offset == `LD_ADDR_W'(`LD_FINISH_OFS));
   assign wr         = cmd_v_i & (cmd_i.op == LD_OP_WRITE);

   // Bit 0 is the finish register, the rest match the device latency
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         freeze_r  <= 1'b0;
         finish_sr <= '0;
      end
      else
      begin
         if (wr && is_freeze)
            freeze_r <= cmd_i.data[0];
         finish_sr[0] <= finish_sr[0] | (wr & is_finish);
         for (int i = 1; i < `LD_DEV_LATENCY; i++)
            finish_sr[i] <= finish_sr[i-1];
      end
   end

   always_comb
   begin
      resp.src  = cmd_i.src;
      resp.data = '0;
      if (cmd_i.op == LD_OP_READ && is_freeze)
         resp.data[0] = freeze_r;
   end

   assign freeze_o         = freeze_r;
   assign program_finish_o = finish_sr[`LD_DEV_LATENCY-1];

   delay_line
   #(
      .payload_t(ld_resp_s),
      .depth_p  (`LD_DEV_LATENCY)
   )
   resp_delay
   (
      .clk_i (clk_i)
      ,.rst_i (rst_i)
      ,.v_i   (cmd_v_i)
      ,.data_i(resp)
      ,.v_o   (resp_v_o)
      ,.data_o(resp_o)
   );

   // Low byte of the write data is the character
   delay_line
   #(
      .payload_t(logic [7:0]),
      .depth_p  (`LD_DEV_LATENCY)
   )
   char_delay
   (
      .clk_i (clk_i)
      ,.rst_i (rst_i)
      ,.v_i   (wr & is_putchar)
      ,.data_i(cmd_i.data[7:0])
      ,.v_o   (char_v_o)
      ,.data_o(char_o)
   );

endmodule

/* logic/mem_model.sv */
// ----------------------------
// Word memory
// Applies writes on receipt and
// answers after device latency
// ----------------------------

`include "loader_macros.svh"

module mem_model
(
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 cmd_v_i,
   input  loader_pkg::ld_cmd_s  cmd_i,
   output logic                 resp_v_o,
   output loader_pkg::ld_resp_s resp_o
);

   import loader_pkg::*;

   localparam int idx_w_lp = $clog2(`LD_MEM_WORDS);

   logic [`LD_DATA_W-1:0] mem_r [`LD_MEM_WORDS];
   logic [idx_w_lp-1:0]   idx;
   logic                  wr;
   ld_resp_s              resp;

   // Index from the low word address bits
   assign idx = cmd_i.addr[idx_w_lp-1:0];
   assign wr  = cmd_v_i & (cmd_i.op == LD_OP_WRITE);

   always_ff @(posedge clk_i)
   begin
      if (wr)
         mem_r[idx] <= cmd_i.data;
   end

   // Read data is taken before a same-cycle write lands
   always_comb
   begin
      resp.src  = cmd_i.src;
      resp.data = (cmd_i.op == LD_OP_READ) ? mem_r[idx] : '0;
   end

   delay_line
   #(
      .payload_t(ld_resp_s),
      .depth_p  (`LD_DEV_LATENCY)
   )
   resp_delay
   (
      .clk_i (clk_i)
      ,.rst_i (rst_i)
      ,.v_i   (cmd_v_i)
      ,.data_i(resp)
      ,.v_o   (resp_v_o)
      ,.data_o(resp_o)
   );

endmodule

/* logic/addr_router.sv */
// ----------------------------
// Address router
// Sends commands to memory or
// host, steers responses back
// ----------------------------

`include "loader_macros.svh"

module addr_router
(
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  cmd_v_i,
   input  loader_pkg::ld_cmd_s   cmd_i,
   output logic                  mem_cmd_v_o,
   output logic                  host_cmd_v_o,
   output loader_pkg::ld_cmd_s   dev_cmd_o,
   input  logic                  mem_resp_v_i,
   input  loader_pkg::ld_resp_s  mem_resp_i,
   input  logic                  host_resp_v_i,
   input  loader_pkg::ld_resp_s  host_resp_i,
   output logic                  cfg_resp_v_o,
   output logic                  resp_v_o,
   output logic [`LD_DATA_W-1:0] resp_data_o
);

   import loader_pkg::*;

   logic     host_sel;
   logic     mem_v_r;
   logic     host_v_r;
   ld_cmd_s  cmd_r;
   logic     resp_v;
   ld_resp_s resp;

   assign host_sel = (cmd_i.addr >= `LD_ADDR_W'(`LD_HOST_BASE));

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         mem_v_r  <= 1'b0;
         host_v_r <= 1'b0;
      end
      else
      begin
         mem_v_r  <= cmd_v_i & ~host_sel;
         host_v_r <= cmd_v_i & host_sel;
      end
   end

   always_ff @(posedge clk_i)
   begin
      cmd_r <= cmd_i;
   end

   assign mem_cmd_v_o  = mem_v_r;
   assign host_cmd_v_o = host_v_r;
   assign dev_cmd_o    = cmd_r;

   // Equal device latency, at most one response per cycle
   assign resp_v = mem_resp_v_i | host_resp_v_i;
   assign resp   = host_resp_v_i ? host_resp_i : mem_resp_i;

   assign cfg_resp_v_o = resp_v & (resp.src == LD_SRC_CFG);
   assign resp_v_o     = resp_v & (resp.src == LD_SRC_LOAD);
   assign resp_data_o  = resp.data;

endmodule

/* logic/load_arbiter.sv */
// ----------------------------
// Load arbiter
// Fixed choice between config
// and nbf load commands
// ----------------------------

`include "loader_macros.svh"

module load_arbiter
(
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  cfg_cmd_v_i,
   input  loader_pkg::ld_cmd_s   cfg_cmd_i,
   input  logic                  cfg_done_i,
   input  logic                  nbf_v_i,
   input  loader_pkg::ld_op_e    nbf_op_i,
   input  logic [`LD_ADDR_W-1:0] nbf_addr_i,
   input  logic [`LD_DATA_W-1:0] nbf_data_i,
   output logic                  nbf_ready_o,
   output logic                  cmd_v_o,
   output loader_pkg::ld_cmd_s   cmd_o
);

   import loader_pkg::*;

   ld_cmd_s nbf_cmd;
   ld_cmd_s cmd_r;
   logic    cmd_v_r;

   always_comb
   begin
      nbf_cmd.op   = nbf_op_i;
      nbf_cmd.src  = LD_SRC_LOAD;
      nbf_cmd.addr = nbf_addr_i;
      nbf_cmd.data = nbf_data_i;
   end

   // Config and nbf never overlap, so done alone picks the source
   assign nbf_ready_o = cfg_done_i;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         cmd_v_r <= 1'b0;
      else
         cmd_v_r <= cfg_done_i ? nbf_v_i : cfg_cmd_v_i;
   end

   always_ff @(posedge clk_i)
   begin
      cmd_r <= cfg_done_i ? nbf_cmd : cfg_cmd_i;
   end

   assign cmd_v_o = cmd_v_r;
   assign cmd_o   = cmd_r;

endmodule

/* logic/cfg_sequencer.sv */
// ----------------------------
// Configuration sequencer
// Freezes the system, clears the
// low memory words, unfreezes,
// then waits for every ack
// ----------------------------

`include "loader_macros.svh"

module cfg_sequencer
#(
   parameter bit skip_init_p = 0
)
(
   input  logic                clk_i,
   input  logic                rst_i,
   output logic                cfg_cmd_v_o,
   output loader_pkg::ld_cmd_s cfg_cmd_o,
   input  logic                cfg_resp_v_i,
   output logic                cfg_done_o
);

   import loader_pkg::*;

   localparam int total_lp = skip_init_p ? 2 : 2 + `LD_CFG_ELS;
   localparam int cnt_w_lp = $clog2(total_lp + 1);
   localparam logic [`LD_ADDR_W-1:0] freeze_addr_lp = `LD_HOST_BASE + `LD_FREEZE_OFS;

   typedef enum logic [1:0]
   {
      STEP_FREEZE,
      STEP_CLEAR,
      STEP_THAW,
      STEP_IDLE
   } step_e;

   step_e               step_r;
   logic [cnt_w_lp-1:0] issue_cnt_r;
   logic [cnt_w_lp-1:0] ack_cnt_r;
   logic [cnt_w_lp-1:0] clear_idx;
   logic                last_clear;
   logic                cmd_v_r;
   logic                done_r;
   ld_cmd_s             cmd_r;

   // The freeze write is issue 0, so clear words start at issue 1
   assign clear_idx  = issue_cnt_r - cnt_w_lp'(1);
   assign last_clear = (clear_idx == cnt_w_lp'(`LD_CFG_ELS - 1));

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         step_r      <= STEP_FREEZE;
         issue_cnt_r <= '0;
         ack_cnt_r   <= '0;
         cmd_v_r     <= 1'b0;
         done_r      <= 1'b0;
      end
      else
      begin
         cmd_v_r <= (step_r != STEP_IDLE);
         if (step_r != STEP_IDLE)
            issue_cnt_r <= issue_cnt_r + 1'b1;

         case (step_r)
            STEP_FREEZE:
            begin
               if (skip_init_p)
                  step_r <= STEP_THAW;
               else
                  step_r <= STEP_CLEAR;
            end
            STEP_CLEAR:
            begin
               if (last_clear)
                  step_r <= STEP_THAW;
            end
            default: step_r <= STEP_IDLE;
         endcase

         if (cfg_resp_v_i)
            ack_cnt_r <= ack_cnt_r + 1'b1;

         // Done once everything issued has been acknowledged
         if (cfg_resp_v_i && ack_cnt_r == cnt_w_lp'(total_lp - 1)
             && issue_cnt_r == cnt_w_lp'(total_lp))
            done_r <= 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      cmd_r.op  <= LD_OP_WRITE;
      cmd_r.src <= LD_SRC_CFG;
      case (step_r)
         STEP_FREEZE:
         begin
            cmd_r.addr <= freeze_addr_lp;
            cmd_r.data <= `LD_DATA_W'(1);
         end
         STEP_CLEAR:
         begin
            cmd_r.addr <= `LD_ADDR_W'(clear_idx);
            cmd_r.data <= '0;
         end
         default:
         begin
            cmd_r.addr <= freeze_addr_lp;
            cmd_r.data <= '0;
         end
      endcase
   end

   assign cfg_cmd_v_o = cmd_v_r;
   assign cfg_cmd_o   = cmd_r;
   assign cfg_done_o  = done_r;

endmodule

/* logic/delay_line.sv */
// ----------------------------
// Delay line
// Fixed-depth chain of valid
// tagged registers, any payload
// ----------------------------

module delay_line
#(
   parameter type payload_t = loader_pkg::ld_resp_s,
   parameter int  depth_p   = 3
)
(
   input  logic     clk_i,
   input  logic     rst_i,
   input  logic     v_i,
   input  payload_t data_i,
   output logic     v_o,
   output payload_t data_o
);

   logic     v_r    [depth_p];
   payload_t data_r [depth_p];

   // Only the valid tags are cleared
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         for (int i = 0; i < depth_p; i++)
            v_r[i] <= 1'b0;
      end
      else
      begin
         v_r[0] <= v_i;
         for (int i = 1; i < depth_p; i++)
            v_r[i] <= v_r[i-1];
      end
   end

   always_ff @(posedge clk_i)
   begin
      data_r[0] <= data_i;
      for (int i = 1; i < depth_p; i++)
         data_r[i] <= data_r[i-1];
   end

   assign v_o    = v_r[depth_p-1];
   assign data_o = data_r[depth_p-1];

endmodule

/* logic/loader_pkg.sv */
// ----------------------------
// Boot loader package
// Opcode, source, command and
// response types
// ----------------------------

`include "loader_macros.svh"

package loader_pkg;

   // Command opcode
   typedef enum logic
   {
      LD_OP_READ  = 1'b0,
      LD_OP_WRITE = 1'b1
   } ld_op_e;

   // Originator, used to steer the response back
   typedef enum logic
   {
      LD_SRC_CFG  = 1'b0,
      LD_SRC_LOAD = 1'b1
   } ld_src_e;

   typedef struct packed
   {
      ld_op_e                 op;
      ld_src_e                src;
      logic [`LD_ADDR_W-1:0]  addr;
      logic [`LD_DATA_W-1:0]  data;
   } ld_cmd_s;

   // Write responses carry zero data
   typedef struct packed
   {
      ld_src_e                src;
      logic [`LD_DATA_W-1:0]  data;
   } ld_resp_s;

endpackage

/* logic/loader_macros.svh */
// ----------------------------
// Boot loader constants
// Widths, device latency, memory
// size and the host MMIO map
// ----------------------------

`ifndef LOADER_MACROS_SVH
`define LOADER_MACROS_SVH

// Command address and data widths
`define LD_ADDR_W       32
`define LD_DATA_W       64

// Memory depth in words, upper address bits are ignored
`define LD_MEM_WORDS    256

// Words zeroed by the configuration sequencer
`define LD_CFG_ELS      8

// Cycles from device receipt to device response
`define LD_DEV_LATENCY  3

// Host window, everything below goes to memory
`define LD_HOST_BASE    32'h0010_0000

// Register offsets inside the host window
`define LD_FREEZE_OFS   0
`define LD_PUTCHAR_OFS  8
`define LD_FINISH_OFS   16

`endif
